/* verilog/core_pkg.sv */
package core_pkg;

    // ======================================================================
    // Core-wide word size and fetch constants
    // ======================================================================

    // Data path width.
    localparam int XLEN = 32;

    // One machine word, used for addresses, instructions and targets.
    typedef logic [XLEN-1:0] data_word_t;

    // Program counter step, no compressed instructions.
    localparam int INSTR_BYTES = 4;

    // First address fetched after reset.
    localparam data_word_t RESET_PC = 32'h0000_0100;

endpackage : core_pkg

/* verilog/btb_pkg.sv */
package btb_pkg;

    // ======================================================================
    // Branch target buffer geometry
    // ======================================================================

    localparam int BTB_ENTRIES = 64;
    localparam int INDEX_BITS = $clog2(BTB_ENTRIES);

    // Word address bits above the index form the tag.
    localparam int TAG_BITS = 32 - INDEX_BITS - 2;

    typedef logic [INDEX_BITS-1:0] btb_index_t;
    typedef logic [TAG_BITS-1:0] btb_tag_t;

    // ======================================================================
    // Direction counter and entry layout
    // ======================================================================

    // Two-bit saturating counter, upper bit set means predict taken.
    typedef logic [1:0] counter_t;

    localparam counter_t COUNTER_WEAK_TAKEN = 2'd2;
    localparam counter_t COUNTER_WEAK_NOT_TAKEN = 2'd1;

    typedef struct packed {
        btb_tag_t             tag;
        core_pkg::data_word_t target;
        logic                 is_branch;
        counter_t             counter;
    } btb_entry_t;

endpackage : btb_pkg

/* verilog/btb_if.sv */
// ==========================================================================
// Lookup path, fetch unit to target buffer
// ==========================================================================

interface btb_lookup_if;
    core_pkg::data_word_t pc;
    logic                 hit;
    core_pkg::data_word_t target;
    logic                 is_branch;
    btb_pkg::counter_t    counter;

    modport requester (output pc, input hit, target, is_branch, counter);
    modport responder (input pc, output hit, target, is_branch, counter);
endinterface : btb_lookup_if

// ==========================================================================
// Update path, resolve unit to target buffer
// ==========================================================================

// The table takes a write on every edge where valid is high.
interface btb_update_if;
    logic                 valid;
    core_pkg::data_word_t pc;
    core_pkg::data_word_t target;
    logic                 is_branch;
    btb_pkg::counter_t    counter;

    modport writer (output valid, pc, target, is_branch, counter);
    modport tbl (input valid, pc, target, is_branch, counter);
endinterface : btb_update_if

/* verilog/branch_target_buffer.sv */
module branch_target_buffer (
    input logic clk_i,
    input logic arst_n_i,

    btb_lookup_if.responder lookup,
    btb_update_if.tbl       update
);

    // ======================================================================
    // Index and tag split
    // ======================================================================

    btb_pkg::btb_index_t rd_index;
    btb_pkg::btb_index_t wr_index;
    btb_pkg::btb_tag_t   rd_tag;
    btb_pkg::btb_tag_t   wr_tag;

    // Word address bits select the entry.
    assign rd_index = lookup.pc[btb_pkg::INDEX_BITS+1:2];
    assign wr_index = update.pc[btb_pkg::INDEX_BITS+1:2];

    assign rd_tag = lookup.pc[core_pkg::XLEN-1:btb_pkg::INDEX_BITS+2];
    assign wr_tag = update.pc[core_pkg::XLEN-1:btb_pkg::INDEX_BITS+2];

    // ======================================================================
    // Entry storage
    // ======================================================================

    btb_pkg::btb_entry_t entry_mem [btb_pkg::BTB_ENTRIES];
    btb_pkg::btb_entry_t wr_entry;
    btb_pkg::btb_entry_t rd_entry;

    always_comb begin
        wr_entry.tag = wr_tag;
        wr_entry.target = update.target;
        wr_entry.is_branch = update.is_branch;
        wr_entry.counter = update.counter;
    end

    always_ff @(posedge clk_i) begin : entry_write
        if (update.valid) begin
            entry_mem[wr_index] <= wr_entry;
        end
    end : entry_write

    // Valid bits, cleared on reset.
    logic [btb_pkg::BTB_ENTRIES-1:0] valid_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_bits
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (update.valid) begin
            valid_q[wr_index] <= 1'b1;
        end
    end : valid_bits

    // ======================================================================
    // Combinational lookup
    // ======================================================================

    // A write in this cycle lands at the edge, so the read sees old data.
    assign rd_entry = entry_mem[rd_index];

    assign lookup.hit = valid_q[rd_index] && (rd_entry.tag == rd_tag);

    // Miss reports zeros.
    assign lookup.target = lookup.hit ? rd_entry.target : '0;
    assign lookup.is_branch = lookup.hit & rd_entry.is_branch;
    assign lookup.counter = lookup.hit ? rd_entry.counter : '0;

endmodule : branch_target_buffer

/* verilog/fetch_unit.sv */
module fetch_unit (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    // Wishbone classic master.
    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output core_pkg::data_word_t wb_adr_o,
    input  logic                 wb_ack_i,
    input  core_pkg::data_word_t wb_dat_i,

    btb_lookup_if.requester      lookup,

    input  logic                 redirect_valid_i,
    input  core_pkg::data_word_t redirect_pc_i,

    output logic                 fetch_valid_o,
    input  logic                 fetch_ready_i,
    output core_pkg::data_word_t fetch_pc_o,
    output core_pkg::data_word_t fetch_instr_o,
    output logic                 fetch_pred_hit_o,
    output logic                 fetch_pred_taken_o,
    output core_pkg::data_word_t fetch_pred_target_o,
    output btb_pkg::counter_t    fetch_pred_counter_o
);

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_BUS,
        FETCH_HOLD
    } fetch_state_t;

    fetch_state_t         state_q;
    core_pkg::data_word_t pc_q;
    core_pkg::data_word_t adr_q;
    logic                 discard_q;

    // ======================================================================
    // Prediction and next PC
    // ======================================================================

    logic                 pred_taken;
    core_pkg::data_word_t next_pc;
    logic                 bus_done;

    // Look up the address currently on the bus.
    assign lookup.pc = adr_q;

    // Jumps are taken on any hit, branches follow the counter.
    assign pred_taken = lookup.hit & (~lookup.is_branch | lookup.counter[1]);
    assign next_pc = pred_taken ? lookup.target
                                : adr_q + core_pkg::data_word_t'(core_pkg::INSTR_BYTES);

    assign bus_done = (state_q == FETCH_BUS) && wb_ack_i;

    // ======================================================================
    // Fetch FSM
    // ======================================================================

    always_ff @(posedge clk_i or negedge arst_n_i) begin : fetch_fsm
        if (!arst_n_i) begin
            state_q <= FETCH_IDLE;
            pc_q <= core_pkg::RESET_PC;
            adr_q <= core_pkg::RESET_PC;
            discard_q <= 1'b0;
        end else begin
            case (state_q)
                FETCH_IDLE: begin
                    if (redirect_valid_i) begin
                        pc_q <= redirect_pc_i;
                    end else if (fetch_ready_i) begin
                        state_q <= FETCH_BUS;
                        adr_q <= pc_q;
                    end
                end
                FETCH_BUS: begin
                    // Address stays on the bus, the redirect waits in pc_q.
                    if (redirect_valid_i) begin
                        pc_q <= redirect_pc_i;
                    end
                    if (wb_ack_i) begin
                        discard_q <= 1'b0;
                        if (discard_q || redirect_valid_i) begin
                            state_q <= FETCH_IDLE;
                        end else begin
                            state_q <= FETCH_HOLD;
                            pc_q <= next_pc;
                        end
                    end else if (redirect_valid_i) begin
                        discard_q <= 1'b1;
                    end
                end
                FETCH_HOLD: begin
                    if (redirect_valid_i) begin
                        state_q <= FETCH_IDLE;
                        pc_q <= redirect_pc_i;
                    end else if (fetch_ready_i) begin
                        state_q <= FETCH_BUS;
                        adr_q <= pc_q;
                    end
                end
                default: begin
                    state_q <= FETCH_IDLE;
                end
            endcase
        end
    end : fetch_fsm

    // Result payload, captured in the ack cycle.
    core_pkg::data_word_t instr_q;
    logic                 pred_hit_q;
    logic                 pred_taken_q;
    core_pkg::data_word_t pred_target_q;
    btb_pkg::counter_t    pred_counter_q;

    always_ff @(posedge clk_i) begin : result_capture
        if (bus_done) begin
            instr_q <= wb_dat_i;
            pred_hit_q <= lookup.hit;
            pred_taken_q <= pred_taken;
            pred_target_q <= lookup.target;
            pred_counter_q <= lookup.counter;
        end
    end : result_capture

    // ======================================================================
    // Outputs
    // ======================================================================

    assign wb_cyc_o = (state_q == FETCH_BUS);
    assign wb_stb_o = wb_cyc_o;
    assign wb_adr_o = adr_q;

    assign fetch_valid_o = (state_q == FETCH_HOLD);
    assign fetch_pc_o = adr_q;
    assign fetch_instr_o = instr_q;
    assign fetch_pred_hit_o = pred_hit_q;
    assign fetch_pred_taken_o = pred_taken_q;
    assign fetch_pred_target_o = pred_target_q;
    assign fetch_pred_counter_o = pred_counter_q;

endmodule : fetch_unit

/* verilog/branch_resolve_unit.sv */
module branch_resolve_unit (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    // Resolved outcome from the execute stage.
    input  logic                 resolve_valid_i,
    input  core_pkg::data_word_t resolve_pc_i,
    input  core_pkg::data_word_t resolve_target_i,
    input  logic                 resolve_is_branch_i,
    input  logic                 resolve_taken_i,

    // Prediction that travelled with the instruction.
    input  logic                 resolve_pred_hit_i,
    input  logic                 resolve_pred_taken_i,
    input  core_pkg::data_word_t resolve_pred_target_i,
    input  btb_pkg::counter_t    resolve_pred_counter_i,

    btb_update_if.writer         update,

    output logic                 redirect_valid_o,
    output core_pkg::data_word_t redirect_pc_o
);

    // ======================================================================
    // Outcome evaluation
    // ======================================================================

    logic                 taken;
    logic                 mispredict;
    logic                 write_entry;
    btb_pkg::counter_t    counter_next;
    core_pkg::data_word_t fallthrough_pc;

    // A jump is always taken.
    assign taken = resolve_taken_i | ~resolve_is_branch_i;

    assign mispredict = (resolve_pred_taken_i != taken)
                     || (taken && (resolve_pred_target_i != resolve_target_i));

    assign write_entry = taken | resolve_pred_hit_i;

    assign fallthrough_pc = resolve_pc_i + core_pkg::data_word_t'(core_pkg::INSTR_BYTES);

    // Saturating counter step on a hit and a fresh weak taken state on a miss.
    always_comb begin
        if (resolve_pred_hit_i) begin
            if (taken) begin
                counter_next = (resolve_pred_counter_i == 2'b11) ? 2'b11
                                                                 : resolve_pred_counter_i + 2'd1;
            end else begin
                counter_next = (resolve_pred_counter_i == 2'b00) ? 2'b00
                                                                 : resolve_pred_counter_i - 2'd1;
            end
        end else begin
            counter_next = btb_pkg::COUNTER_WEAK_TAKEN;
        end
    end

    // ======================================================================
    // Registered update and redirect
    // ======================================================================

    logic upd_valid_q;
    logic redirect_valid_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin : pulse_regs
        if (!arst_n_i) begin
            upd_valid_q <= 1'b0;
            redirect_valid_q <= 1'b0;
        end else begin
            upd_valid_q <= resolve_valid_i & write_entry;
            redirect_valid_q <= resolve_valid_i & mispredict;
        end
    end : pulse_regs

    core_pkg::data_word_t upd_pc_q;
    core_pkg::data_word_t upd_target_q;
    logic                 upd_is_branch_q;
    btb_pkg::counter_t    upd_counter_q;
    core_pkg::data_word_t redirect_pc_q;

    always_ff @(posedge clk_i) begin : payload_regs
        if (resolve_valid_i) begin
            upd_pc_q <= resolve_pc_i;
            upd_target_q <= resolve_target_i;
            upd_is_branch_q <= resolve_is_branch_i;
            upd_counter_q <= counter_next;
            redirect_pc_q <= taken ? resolve_target_i : fallthrough_pc;
        end
    end : payload_regs

    assign update.valid = upd_valid_q;
    assign update.pc = upd_pc_q;
    assign update.target = upd_target_q;
    assign update.is_branch = upd_is_branch_q;
    assign update.counter = upd_counter_q;

    assign redirect_valid_o = redirect_valid_q;
    assign redirect_pc_o = redirect_pc_q;

endmodule : branch_resolve_unit

/* verilog/branch_frontend.sv */
module branch_frontend (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    // Wishbone classic instruction port.
    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output core_pkg::data_word_t wb_adr_o,
    input  logic                 wb_ack_i,
    input  core_pkg::data_word_t wb_dat_i,

    // Fetch output.
    output logic                 fetch_valid_o,
    input  logic                 fetch_ready_i,
    output core_pkg::data_word_t fetch_pc_o,
    output core_pkg::data_word_t fetch_instr_o,
    output logic                 fetch_pred_hit_o,
    output logic                 fetch_pred_taken_o,
    output core_pkg::data_word_t fetch_pred_target_o,
    output btb_pkg::counter_t    fetch_pred_counter_o,

    // Resolve input from execute.
    input  logic                 resolve_valid_i,
    input  core_pkg::data_word_t resolve_pc_i,
    input  core_pkg::data_word_t resolve_target_i,
    input  logic                 resolve_is_branch_i,
    input  logic                 resolve_taken_i,
    input  logic                 resolve_pred_hit_i,
    input  logic                 resolve_pred_taken_i,
    input  core_pkg::data_word_t resolve_pred_target_i,
    input  btb_pkg::counter_t    resolve_pred_counter_i
);

    btb_lookup_if btb_lookup ();
    btb_update_if btb_update ();

    logic                 redirect_valid;
    core_pkg::data_word_t redirect_pc;

    fetch_unit u_fetch (
        .clk_i                (clk_i),
        .arst_n_i             (arst_n_i),
        .wb_cyc_o             (wb_cyc_o),
        .wb_stb_o             (wb_stb_o),
        .wb_adr_o             (wb_adr_o),
        .wb_ack_i             (wb_ack_i),
        .wb_dat_i             (wb_dat_i),
        .lookup               (btb_lookup.requester),
        .redirect_valid_i     (redirect_valid),
        .redirect_pc_i        (redirect_pc),
        .fetch_valid_o        (fetch_valid_o),
        .fetch_ready_i        (fetch_ready_i),
        .fetch_pc_o           (fetch_pc_o),
        .fetch_instr_o        (fetch_instr_o),
        .fetch_pred_hit_o     (fetch_pred_hit_o),
        .fetch_pred_taken_o   (fetch_pred_taken_o),
        .fetch_pred_target_o  (fetch_pred_target_o),
        .fetch_pred_counter_o (fetch_pred_counter_o)
    );

    branch_target_buffer u_btb (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .lookup   (btb_lookup.responder),
        .update   (btb_update.tbl)
    );

    branch_resolve_unit u_resolve (
        .clk_i                  (clk_i),
        .arst_n_i               (arst_n_i),
        .resolve_valid_i        (resolve_valid_i),
        .resolve_pc_i           (resolve_pc_i),
        .resolve_target_i       (resolve_target_i),
        .resolve_is_branch_i    (resolve_is_branch_i),
        .resolve_taken_i        (resolve_taken_i),
        .resolve_pred_hit_i     (resolve_pred_hit_i),
        .resolve_pred_taken_i   (resolve_pred_taken_i),
        .resolve_pred_target_i  (resolve_pred_target_i),
        .resolve_pred_counter_i (resolve_pred_counter_i),
        .update                 (btb_update.writer),
        .redirect_valid_o       (redirect_valid),
        .redirect_pc_o          (redirect_pc)
    );

endmodule : branch_frontend

/* sim/frontend_assert.sv */
module frontend_assert (
    input logic                 clk_i,
    input logic                 arst_n_i,
    input logic                 wb_cyc_o,
    input logic                 wb_stb_o,
    input core_pkg::data_word_t wb_adr_o,
    input logic                 wb_ack_i,
    input logic                 fetch_valid_o,
    input logic                 fetch_ready_i,
    input core_pkg::data_word_t fetch_pc_o,
    input core_pkg::data_word_t fetch_instr_o,
    input logic                 fetch_pred_hit_o,
    input logic                 fetch_pred_taken_o,
    input core_pkg::data_word_t fetch_pred_target_o,
    input btb_pkg::counter_t    fetch_pred_counter_o,
    input logic                 redirect_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // ======================================================================
    // Wishbone classic master
    // ======================================================================

    stb_follows_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_stb_o == wb_cyc_o)
        else $error("Wishbone stb differs from cyc");

    cycle_held_until_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (wb_cyc_o && !wb_ack_i) |=> (wb_cyc_o && $stable(wb_adr_o)))
        else $error("Wishbone cycle or address changed before ack");

    // ======================================================================
    // Fetch output and redirect
    // ======================================================================

    // A redirect may drop a held result, otherwise it must wait for ready.
    output_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (fetch_valid_o && !fetch_ready_i && !redirect_valid) |=>
        (fetch_valid_o && $stable(fetch_pc_o) && $stable(fetch_instr_o)
         && $stable(fetch_pred_hit_o) && $stable(fetch_pred_taken_o)
         && $stable(fetch_pred_target_o) && $stable(fetch_pred_counter_o)))
        else $error("Fetch output changed while not accepted");

    redirect_single_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        redirect_valid |=> !redirect_valid)
        else $error("Redirect stayed high for more than one cycle");

endmodule : frontend_assert

bind branch_frontend frontend_assert u_frontend_assert (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .wb_cyc_o             (wb_cyc_o),
    .wb_stb_o             (wb_stb_o),
    .wb_adr_o             (wb_adr_o),
    .wb_ack_i             (wb_ack_i),
    .fetch_valid_o        (fetch_valid_o),
    .fetch_ready_i        (fetch_ready_i),
    .fetch_pc_o           (fetch_pc_o),
    .fetch_instr_o        (fetch_instr_o),
    .fetch_pred_hit_o     (fetch_pred_hit_o),
    .fetch_pred_taken_o   (fetch_pred_taken_o),
    .fetch_pred_target_o  (fetch_pred_target_o),
    .fetch_pred_counter_o (fetch_pred_counter_o),
    .redirect_valid       (redirect_valid)
);

/* sim/frontend_tb.sv */
module frontend_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        core_pkg::data_word_t pc;
        core_pkg::data_word_t instr;
        logic                 hit;
        logic                 taken;
        core_pkg::data_word_t target;
        btb_pkg::counter_t    counter;
    } fetch_rec_t;

    logic                 clk_i;
    logic                 arst_n_i;
    logic                 wb_cyc_o;
    logic                 wb_stb_o;
    core_pkg::data_word_t wb_adr_o;
    logic                 wb_ack_i;
    core_pkg::data_word_t wb_dat_i;
    logic                 fetch_valid_o;
    logic                 fetch_ready_i;
    core_pkg::data_word_t fetch_pc_o;
    core_pkg::data_word_t fetch_instr_o;
    logic                 fetch_pred_hit_o;
    logic                 fetch_pred_taken_o;
    core_pkg::data_word_t fetch_pred_target_o;
    btb_pkg::counter_t    fetch_pred_counter_o;
    logic                 resolve_valid_i;
    core_pkg::data_word_t resolve_pc_i;
    core_pkg::data_word_t resolve_target_i;
    logic                 resolve_is_branch_i;
    logic                 resolve_taken_i;
    logic                 resolve_pred_hit_i;
    logic                 resolve_pred_taken_i;
    core_pkg::data_word_t resolve_pred_target_i;
    btb_pkg::counter_t    resolve_pred_counter_i;

    branch_frontend DUT (.*);

    // ======================================================================
    // Reference predictor and testbench state
    // ======================================================================

    logic                 m_valid [btb_pkg::BTB_ENTRIES];
    btb_pkg::btb_tag_t    m_tag [btb_pkg::BTB_ENTRIES];
    core_pkg::data_word_t m_target [btb_pkg::BTB_ENTRIES];
    logic                 m_is_branch [btb_pkg::BTB_ENTRIES];
    btb_pkg::counter_t    m_counter [btb_pkg::BTB_ENTRIES];

    logic                 pend_valid;
    logic                 pend_mispredict;
    logic                 pend_write;
    core_pkg::data_word_t pend_redirect_pc;
    core_pkg::data_word_t pend_pc;
    core_pkg::data_word_t pend_target;
    logic                 pend_is_branch;
    btb_pkg::counter_t    pend_counter;

    fetch_rec_t           held;
    logic                 held_valid;
    fetch_rec_t           accepted_rec;
    logic                 accepted_last;
    core_pkg::data_word_t exp_pc;
    logic                 discard;
    logic                 prev_cyc;
    logic                 prev_ready;
    logic [31:0]          rng_state;
    logic [1:0]           wait_cnt;
    int                   quiet_cycles;
    int                   accept_count;
    int                   idle_cycles;

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 8;
    endfunction

    // Instruction word derived from every address bit.
    function automatic core_pkg::data_word_t mem_word(input core_pkg::data_word_t addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h9E37_79B9);
    endfunction

    // Few indices with several tags each so that entries alias.
    function automatic core_pkg::data_word_t pool_addr(input logic [2:0] sel);
        case (sel)
            3'd0: return 32'h0000_0100;
            3'd1: return 32'h0000_1100;
            3'd2: return 32'h0000_2100;
            3'd3: return 32'h0000_0110;
            3'd4: return 32'h0000_1110;
            3'd5: return 32'h0000_0120;
            3'd6: return 32'h0000_3120;
            default: return 32'h0000_0200;
        endcase
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            fail_now("Value mismatch");
        end
    endtask

    task automatic model_lookup(input core_pkg::data_word_t pc, output fetch_rec_t rec);
        btb_pkg::btb_index_t idx;
        idx = pc[btb_pkg::INDEX_BITS+1:2];
        rec.pc = pc;
        rec.instr = mem_word(pc);
        rec.hit = m_valid[idx] && (m_tag[idx] == pc[31:btb_pkg::INDEX_BITS+2]);
        rec.target = rec.hit ? m_target[idx] : '0;
        rec.counter = rec.hit ? m_counter[idx] : '0;
        // Jumps go on any hit and branches follow the counter.
        rec.taken = rec.hit && (!m_is_branch[idx] || m_counter[idx][1]);
    endtask

    task automatic model_resolve();
        logic taken;
        taken = resolve_taken_i || !resolve_is_branch_i;
        pend_valid = 1'b1;
        pend_mispredict = (resolve_pred_taken_i != taken)
                       || (taken && (resolve_pred_target_i != resolve_target_i));
        pend_redirect_pc = taken ? resolve_target_i : resolve_pc_i + 32'd4;
        pend_write = taken || resolve_pred_hit_i;
        pend_pc = resolve_pc_i;
        pend_target = resolve_target_i;
        pend_is_branch = resolve_is_branch_i;
        if (!resolve_pred_hit_i) begin
            pend_counter = btb_pkg::COUNTER_WEAK_TAKEN;
        end else if (taken) begin
            pend_counter = (resolve_pred_counter_i == 2'd3) ? 2'd3
                                                            : resolve_pred_counter_i + 2'd1;
        end else begin
            pend_counter = (resolve_pred_counter_i == 2'd0) ? 2'd0
                                                            : resolve_pred_counter_i - 2'd1;
        end
    endtask

    // ======================================================================
    // Per-cycle checks at the falling edge
    // ======================================================================

    task automatic check_cycle();
        logic                redirect_now;
        logic                new_valid;
        fetch_rec_t          rec;
        btb_pkg::btb_index_t idx;
        redirect_now = pend_valid && pend_mispredict;
        new_valid = 1'b0;
        check_value("fetch_valid_o", 32'(fetch_valid_o), 32'(held_valid));
        if (held_valid) begin
            check_value("fetch_pc_o", fetch_pc_o, held.pc);
            check_value("fetch_instr_o", fetch_instr_o, held.instr);
            check_value("fetch_pred_hit_o", 32'(fetch_pred_hit_o), 32'(held.hit));
            check_value("fetch_pred_taken_o", 32'(fetch_pred_taken_o), 32'(held.taken));
            check_value("fetch_pred_target_o", fetch_pred_target_o, held.target);
            check_value("fetch_pred_counter_o", 32'(fetch_pred_counter_o), 32'(held.counter));
        end
        accepted_last = held_valid && fetch_ready_i && !redirect_now;
        if (accepted_last) begin
            accepted_rec = held;
            accept_count++;
            idle_cycles = 0;
        end
        // A new bus cycle needs ready in the cycle before it.
        if (wb_cyc_o && !prev_cyc) begin
            assert (prev_ready) else fail_now("Bus cycle started while ready was low");
            check_value("wb_adr_o", wb_adr_o, exp_pc);
        end
        if (wb_cyc_o && wb_ack_i) begin
            if (!discard && !redirect_now) begin
                model_lookup(wb_adr_o, rec);
                new_valid = 1'b1;
                exp_pc = rec.taken ? rec.target : wb_adr_o + 32'd4;
            end
            discard = 1'b0;
        end else if (wb_cyc_o && redirect_now) begin
            discard = 1'b1;
        end
        if (redirect_now || accepted_last) begin
            held_valid = 1'b0;
        end
        if (new_valid) begin
            held = rec;
            held_valid = 1'b1;
        end
        if (redirect_now) begin
            exp_pc = pend_redirect_pc;
        end
        // Table write lands at the end of the redirect cycle.
        if (pend_valid && pend_write) begin
            idx = pend_pc[btb_pkg::INDEX_BITS+1:2];
            m_valid[idx] = 1'b1;
            m_tag[idx] = pend_pc[31:btb_pkg::INDEX_BITS+2];
            m_target[idx] = pend_target;
            m_is_branch[idx] = pend_is_branch;
            m_counter[idx] = pend_counter;
        end
        pend_valid = 1'b0;
        if (resolve_valid_i) begin
            model_resolve();
        end
        prev_cyc = wb_cyc_o;
        prev_ready = fetch_ready_i;
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================

    initial begin
        logic [31:0] r;
        rng_state = 32'd84700;
        arst_n_i = 1'b0;
        wb_ack_i = 1'b0;
        wb_dat_i = '0;
        fetch_ready_i = 1'b1;
        resolve_valid_i = 1'b0;
        resolve_pc_i = '0;
        resolve_target_i = '0;
        resolve_is_branch_i = 1'b0;
        resolve_taken_i = 1'b0;
        resolve_pred_hit_i = 1'b0;
        resolve_pred_taken_i = 1'b0;
        resolve_pred_target_i = '0;
        resolve_pred_counter_i = '0;
        for (int i = 0; i < btb_pkg::BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        pend_valid = 1'b0;
        held_valid = 1'b0;
        accepted_last = 1'b0;
        exp_pc = core_pkg::RESET_PC;
        discard = 1'b0;
        prev_cyc = 1'b0;
        prev_ready = 1'b1;
        quiet_cycles = 0;
        accept_count = 0;
        idle_cycles = 0;
        r = lcg_next();
        wait_cnt = r[1:0];
        repeat (5) @(posedge clk_i);
        #1 arst_n_i = 1'b1;

        while (accept_count < 400) begin
            @(posedge clk_i);
            #1;
            // Memory model acks after 0 to 3 wait cycles.
            r = lcg_next();
            if (wb_ack_i) begin
                wb_ack_i = 1'b0;
                wait_cnt = r[1:0];
            end else if (wb_cyc_o) begin
                if (wait_cnt == 2'd0) begin
                    wb_ack_i = 1'b1;
                    wb_dat_i = mem_word(wb_adr_o);
                end else begin
                    wait_cnt = wait_cnt - 2'd1;
                end
            end
            // Execute stage resolves about half of the accepted fetches.
            resolve_valid_i = 1'b0;
            if (accepted_last && r[4]) begin
                resolve_valid_i = 1'b1;
                resolve_pc_i = accepted_rec.pc;
                resolve_target_i = pool_addr(r[7:5]);
                resolve_is_branch_i = r[8];
                resolve_taken_i = r[9] || !r[8];
                resolve_pred_hit_i = accepted_rec.hit;
                resolve_pred_taken_i = accepted_rec.taken;
                resolve_pred_target_i = accepted_rec.target;
                resolve_pred_counter_i = accepted_rec.counter;
                quiet_cycles = 2;
            end
            if (quiet_cycles != 0) begin
                fetch_ready_i = 1'b0;
                quiet_cycles--;
            end else begin
                fetch_ready_i = (r[11:10] != 2'd0);
            end
            @(negedge clk_i);
            check_cycle();
            idle_cycles++;
            if (idle_cycles > 100) begin
                fail_now("Timeout: no fetch accepted within 100 cycles");
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule : frontend_tb

/* files.f */
verilog/core_pkg.sv
verilog/btb_pkg.sv
verilog/btb_if.sv
verilog/branch_target_buffer.sv
verilog/fetch_unit.sv
verilog/branch_resolve_unit.sv
verilog/branch_frontend.sv
sim/frontend_assert.sv
sim/frontend_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module frontend_tb \
    -f files.f \
    -o frontend_sim

sim_output=$(./obj_dir/frontend_sim 2>&1) || true
echo "$sim_output"

if grep -q "All checks passed" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi
